// File: branchCondition.sv
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module branchCondition (
    input  logic [`INSTR_WIDTH-1:0] instruction,
    input  cpuControlPkg::flagsT    flags,
    output logic                    branchTaken
);

    cpuControlPkg::conditionT condition;

    assign condition = cpuControlPkg::conditionT'(instruction[`DEST_MSB:`DEST_LSB]);

    // Shared by Jcond and Bcond
    always_comb begin
        branchTaken = 1'b0;
        case (condition)
            cpuControlPkg::EQ: branchTaken = flags.zero;
            cpuControlPkg::NE: branchTaken = !flags.zero;
            cpuControlPkg::CS: branchTaken = flags.carry;
            cpuControlPkg::CC: branchTaken = !flags.carry;
            cpuControlPkg::HI: branchTaken = flags.low;
            cpuControlPkg::LS: branchTaken = !flags.low;
            cpuControlPkg::GT: branchTaken = flags.negative;
            cpuControlPkg::LE: branchTaken = !flags.negative;
            cpuControlPkg::FS: branchTaken = flags.flag;
            cpuControlPkg::FC: branchTaken = !flags.flag;
            cpuControlPkg::LO: begin
                branchTaken = !flags.low && !flags.zero;
            end
            cpuControlPkg::HS: begin
                branchTaken = flags.low || flags.zero;
            end
            cpuControlPkg::LT: begin
                branchTaken = !flags.negative && !flags.zero;
            end
            cpuControlPkg::GE: begin
                branchTaken = flags.negative || flags.zero;
            end
            cpuControlPkg::UC: branchTaken = 1'b1;
            cpuControlPkg::NJ: branchTaken = 1'b0;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// File: controlSequencer.sv
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module controlSequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`INSTR_WIDTH-1:0]     instruction,
    input  cpuControlPkg::decodeT       decoded,
    input  logic                        branchTaken,
    output cpuControlPkg::controlLinesT control
);

    cpuControlPkg::stateT         state;
    cpuControlPkg::stateT         nextState;
    cpuControlPkg::controlLinesT  lines;
    cpuControlPkg::instrClassT    instrClass;

    assign instrClass = decoded.instrClass;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= cpuControlPkg::fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            cpuControlPkg::fetch: nextState = cpuControlPkg::decode;
            cpuControlPkg::decode: begin
                if (instrClass == cpuControlPkg::classIllegal) begin
                    nextState = cpuControlPkg::fetch;   // Skip unknown opcodes
                end else begin
                    nextState = cpuControlPkg::execute;
                end
            end
            cpuControlPkg::execute: begin
                if (instrClass == cpuControlPkg::classCompare) begin
                    nextState = cpuControlPkg::fetch;   // Only flags change
                end else begin
                    nextState = cpuControlPkg::writeBack;
                end
            end
            default: nextState = cpuControlPkg::fetch;
        endcase
    end

    always_comb begin
        lines = '0;
        if (state == cpuControlPkg::execute || state == cpuControlPkg::writeBack) begin
            lines.useImmediate = decoded.useImmediate;
            lines.useRegisterA = decoded.useRegisterA;
            lines.immKind      = decoded.immKind;
        end
        case (state)
            cpuControlPkg::fetch: begin
                lines.ramReadEnable = 1'b1;
                lines.irLoad        = 1'b1;
            end
            cpuControlPkg::decode: begin
                lines.pcEnable = (instrClass == cpuControlPkg::classIllegal);
            end
            cpuControlPkg::execute: begin
                lines.aluEnable = 1'b1;
                if (instrClass == cpuControlPkg::classLoad) begin
                    lines.ramAddrFromAlu = 1'b1;   // Start the RAM read early
                    lines.ramReadEnable  = 1'b1;
                end
                lines.pcEnable = (instrClass == cpuControlPkg::classCompare);
            end
            cpuControlPkg::writeBack: begin
                lines.pcEnable = 1'b1;
                case (instrClass)
                    cpuControlPkg::classAlu: begin
                        lines.regWriteEnable  = 1'b1;
                        lines.regWriteAddress = instruction[`DEST_MSB:`DEST_LSB];
                    end
                    cpuControlPkg::classLoad: begin
                        lines.regWriteEnable   = 1'b1;
                        lines.regWriteAddress  = instruction[`DEST_MSB:`DEST_LSB];
                        lines.writeBackFromRam = 1'b1;
                        lines.ramAddrFromAlu   = 1'b1;
                        lines.ramReadEnable    = 1'b1;
                    end
                    cpuControlPkg::classStore: lines.ramWriteEnable = 1'b1;
                    cpuControlPkg::classJcond,
                    cpuControlPkg::classBcond: lines.pcWrite = branchTaken;
                    cpuControlPkg::classJal: lines.pcWrite = 1'b1;
                    default: lines.pcWrite = 1'b0;
                endcase
            end
            default: lines = '0;
        endcase
    end

    // Datapath sees idle lines throughout reset
    assign control = reset ? lines : '0;

    irLoadNotWithPcEnable: assert property (
        @(posedge clock) !(control.irLoad && control.pcEnable));

    singleWriteTarget: assert property (
        @(posedge clock) !(control.regWriteEnable && control.ramWriteEnable));

    // An illegal opcode must have returned to fetch from decode
    noIllegalExecute: assert property (
        @(posedge clock) disable iff (!reset)
        (state == cpuControlPkg::execute) |-> (instrClass != cpuControlPkg::classIllegal));

endmodule

// File: cpuControl.f
+incdir+.
cpuControlPkg.sv
instructionDecoder.sv
branchCondition.sv
controlSequencer.sv
cpuControl.sv
cpuControlTb.sv

// File: cpuControl.sv
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module cpuControl (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`INSTR_WIDTH-1:0]     instruction,
    input  cpuControlPkg::flagsT        flags,
    output cpuControlPkg::controlLinesT control
);

    cpuControlPkg::decodeT decoded;
    logic                  branchTaken;

    instructionDecoder decoder (
        .instruction (instruction),
        .decoded     (decoded)
    );

    // Evaluated on every instruction, used only by jumps and branches
    branchCondition condition (
        .instruction (instruction),
        .flags       (flags),
        .branchTaken (branchTaken)
    );

    controlSequencer sequencer (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .decoded     (decoded),
        .branchTaken (branchTaken),
        .control     (control)
    );

endmodule

// File: cpuControlPkg.sv
`include "cpuControl_macros.svh"

package cpuControlPkg;

    typedef enum logic [1:0] {
        fetch,
        decode,
        execute,
        writeBack
    } stateT;

    typedef enum logic [3:0] {
        opRType   = 4'b0000,
        opAndi    = 4'b0001,
        opOri     = 4'b0010,
        opXori    = 4'b0011,
        opMemJump = 4'b0100,   // Load, store, Jcond, JAL
        opAddi    = 4'b0101,
        opAddui   = 4'b0110,
        opAddci   = 4'b0111,
        opShift   = 4'b1000,
        opSubi    = 4'b1001,
        opSubci   = 4'b1010,
        opCmpi    = 4'b1011,
        opBcond   = 4'b1100,
        opMovi    = 4'b1101,
        opMuli    = 4'b1110,
        opLui     = 4'b1111
    } opcodeT;

    typedef enum logic [3:0] {
        extLoad  = 4'b0000,
        extStore = 4'b0100,
        extJal   = 4'b1000,
        extCmp   = 4'b1011,   // Only under opRType
        extJcond = 4'b1100
    } extOpT;

    // Register shift codes under opShift
    typedef enum logic [3:0] {
        extLsh = 4'b0100,
        extAsh = 4'b0110
    } shiftExtT;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, HI, LS, GT, LE,
        FS, FC, LO, HS, LT, GE, UC, NJ
    } conditionT;

    typedef enum logic [2:0] {
        classAlu,
        classCompare,
        classLoad,
        classStore,
        classJcond,
        classJal,
        classBcond,
        classIllegal
    } instrClassT;

    typedef enum logic [1:0] {
        immRaw     = 2'd0,
        immSignExt = 2'd1,
        immZeroExt = 2'd2,
        immZero    = 2'd3   // Hard zero operand
    } immKindT;

    typedef struct packed {
        logic negative;
        logic zero;
        logic flag;
        logic low;
        logic carry;
    } flagsT;

    typedef struct packed {
        instrClassT instrClass;
        logic       useImmediate;
        logic       useRegisterA;
        immKindT    immKind;
    } decodeT;

    typedef struct packed {
        logic                         aluEnable;
        logic                         ramReadEnable;
        logic                         irLoad;
        logic                         pcEnable;
        logic                         pcWrite;          // Jump target instead of increment
        logic                         ramWriteEnable;
        logic                         regWriteEnable;
        logic                         useImmediate;
        logic                         useRegisterA;
        immKindT                      immKind;
        logic                         ramAddrFromAlu;
        logic                         writeBackFromRam;
        logic [`REG_ADDR_WIDTH-1:0]   regWriteAddress;
    } controlLinesT;

endpackage

// File: cpuControlTb.sv
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module cpuControlTb;

    localparam int CLOCK_PERIOD     = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_INSTRUCTIONS = 400;
    localparam int WATCHDOG_TIME    = 2 * (NUM_INSTRUCTIONS * 4 + RESET_CYCLES) * CLOCK_PERIOD;

    logic                        clock;
    logic                        reset;
    logic [`INSTR_WIDTH-1:0]     instruction;
    cpuControlPkg::flagsT        flags;
    cpuControlPkg::controlLinesT control;

    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;

    cpuControl UUT (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .flags       (flags),
        .control     (control)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0t: the run hung before all instructions finished",
                 $time);
        $display(">>> FAIL");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic cpuControlPkg::instrClassT modelClass(input logic [15:0] instr);
        logic [3:0]                op;
        logic [3:0]                ext;
        cpuControlPkg::instrClassT cls;
        op  = instr[`OPCODE_MSB:`OPCODE_LSB];
        ext = instr[`EXT_MSB:`EXT_LSB];
        cls = cpuControlPkg::classIllegal;
        case (op)
            cpuControlPkg::opRType: begin
                if (ext == cpuControlPkg::extCmp) cls = cpuControlPkg::classCompare;
                else cls = cpuControlPkg::classAlu;
            end
            cpuControlPkg::opAndi, cpuControlPkg::opOri, cpuControlPkg::opXori,
            cpuControlPkg::opAddi, cpuControlPkg::opSubi, cpuControlPkg::opMovi,
            cpuControlPkg::opLui, cpuControlPkg::opShift: cls = cpuControlPkg::classAlu;
            cpuControlPkg::opCmpi: cls = cpuControlPkg::classCompare;
            cpuControlPkg::opBcond: cls = cpuControlPkg::classBcond;
            cpuControlPkg::opMemJump: begin
                if (ext == cpuControlPkg::extLoad) cls = cpuControlPkg::classLoad;
                else if (ext == cpuControlPkg::extStore) cls = cpuControlPkg::classStore;
                else if (ext == cpuControlPkg::extJcond) cls = cpuControlPkg::classJcond;
                else if (ext == cpuControlPkg::extJal) cls = cpuControlPkg::classJal;
            end
            default: cls = cpuControlPkg::classIllegal;   // ADDUI, ADDCI, SUBCI, MULI
        endcase
        return cls;
    endfunction

    function automatic logic modelTaken(input logic [3:0] cond, input cpuControlPkg::flagsT f);
        logic taken;
        case (cond)
            cpuControlPkg::EQ: taken = f.zero;
            cpuControlPkg::NE: taken = !f.zero;
            cpuControlPkg::CS: taken = f.carry;
            cpuControlPkg::CC: taken = !f.carry;
            cpuControlPkg::HI: taken = f.low;
            cpuControlPkg::LS: taken = !f.low;
            cpuControlPkg::GT: taken = f.negative;
            cpuControlPkg::LE: taken = !f.negative;
            cpuControlPkg::FS: taken = f.flag;
            cpuControlPkg::FC: taken = !f.flag;
            cpuControlPkg::LO: taken = !f.low && !f.zero;
            cpuControlPkg::HS: taken = f.low || f.zero;
            cpuControlPkg::LT: taken = !f.negative && !f.zero;
            cpuControlPkg::GE: taken = f.negative || f.zero;
            cpuControlPkg::UC: taken = 1'b1;
            default: taken = 1'b0;   // NJ
        endcase
        return taken;
    endfunction

    function automatic int modelLength(input cpuControlPkg::instrClassT cls);
        if (cls == cpuControlPkg::classIllegal) return 2;
        if (cls == cpuControlPkg::classCompare) return 3;
        return 4;
    endfunction

    function automatic cpuControlPkg::stateT modelNextState(input cpuControlPkg::stateT st,
                                                          input cpuControlPkg::instrClassT cls);
        cpuControlPkg::stateT next;
        next = cpuControlPkg::fetch;
        if (st == cpuControlPkg::fetch) begin
            next = cpuControlPkg::decode;
        end else if (st == cpuControlPkg::decode) begin
            if (cls != cpuControlPkg::classIllegal) next = cpuControlPkg::execute;
        end else if (st == cpuControlPkg::execute) begin
            if (cls != cpuControlPkg::classCompare) next = cpuControlPkg::writeBack;
        end
        return next;
    endfunction

    // Expected control lines for one cycle
    function automatic cpuControlPkg::controlLinesT modelLines(input cpuControlPkg::stateT st,
                                                               input logic [15:0] instr,
                                                               input cpuControlPkg::flagsT f);
        cpuControlPkg::controlLinesT exp;
        cpuControlPkg::instrClassT   cls;
        cpuControlPkg::immKindT      kind;
        logic                        useImm;
        logic [3:0]                  op;
        logic [3:0]                  ext;
        op     = instr[`OPCODE_MSB:`OPCODE_LSB];
        ext    = instr[`EXT_MSB:`EXT_LSB];
        cls    = modelClass(instr);
        useImm = 1'b0;
        kind   = cpuControlPkg::immRaw;
        case (op)
            cpuControlPkg::opAndi, cpuControlPkg::opOri, cpuControlPkg::opXori,
            cpuControlPkg::opMovi: begin
                useImm = 1'b1;
                kind   = cpuControlPkg::immZeroExt;
            end
            cpuControlPkg::opAddi, cpuControlPkg::opSubi, cpuControlPkg::opCmpi: begin
                useImm = 1'b1;
                kind   = cpuControlPkg::immSignExt;
            end
            cpuControlPkg::opLui, cpuControlPkg::opBcond: useImm = 1'b1;
            cpuControlPkg::opShift: begin
                useImm = !(ext == cpuControlPkg::extLsh || ext == cpuControlPkg::extAsh);
            end
            cpuControlPkg::opMemJump: begin
                if (cls == cpuControlPkg::classStore || cls == cpuControlPkg::classJcond ||
                    cls == cpuControlPkg::classJal) begin
                    useImm = 1'b1;
                    kind   = cpuControlPkg::immZero;
                end
            end
            default: useImm = 1'b0;
        endcase
        exp = '0;
        if (st == cpuControlPkg::execute || st == cpuControlPkg::writeBack) begin
            exp.useImmediate = useImm;
            exp.useRegisterA = (cls != cpuControlPkg::classBcond);
            exp.immKind      = kind;
        end
        if (st == cpuControlPkg::fetch) begin
            exp.ramReadEnable = 1'b1;
            exp.irLoad        = 1'b1;
        end else if (st == cpuControlPkg::decode) begin
            exp.pcEnable = (cls == cpuControlPkg::classIllegal);
        end else if (st == cpuControlPkg::execute) begin
            exp.aluEnable      = 1'b1;
            exp.ramAddrFromAlu = (cls == cpuControlPkg::classLoad);
            exp.ramReadEnable  = (cls == cpuControlPkg::classLoad);
            exp.pcEnable       = (cls == cpuControlPkg::classCompare);
        end else begin
            exp.pcEnable = 1'b1;
            if (cls == cpuControlPkg::classAlu || cls == cpuControlPkg::classLoad) begin
                exp.regWriteEnable  = 1'b1;
                exp.regWriteAddress = instr[`DEST_MSB:`DEST_LSB];
            end
            if (cls == cpuControlPkg::classLoad) begin
                exp.writeBackFromRam = 1'b1;
                exp.ramAddrFromAlu   = 1'b1;
                exp.ramReadEnable    = 1'b1;
            end
            exp.ramWriteEnable = (cls == cpuControlPkg::classStore);
            if (cls == cpuControlPkg::classJcond || cls == cpuControlPkg::classBcond) begin
                exp.pcWrite = modelTaken(instr[`DEST_MSB:`DEST_LSB], f);
            end
            if (cls == cpuControlPkg::classJal) exp.pcWrite = 1'b1;
        end
        return exp;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compareControl(input cpuControlPkg::controlLinesT exp);
        checkValue("control.aluEnable", 32'(exp.aluEnable), 32'(control.aluEnable));
        checkValue("control.ramReadEnable", 32'(exp.ramReadEnable), 32'(control.ramReadEnable));
        checkValue("control.irLoad", 32'(exp.irLoad), 32'(control.irLoad));
        checkValue("control.pcEnable", 32'(exp.pcEnable), 32'(control.pcEnable));
        checkValue("control.pcWrite", 32'(exp.pcWrite), 32'(control.pcWrite));
        checkValue("control.ramWriteEnable", 32'(exp.ramWriteEnable),
                   32'(control.ramWriteEnable));
        checkValue("control.regWriteEnable", 32'(exp.regWriteEnable),
                   32'(control.regWriteEnable));
        checkValue("control.useImmediate", 32'(exp.useImmediate), 32'(control.useImmediate));
        checkValue("control.useRegisterA", 32'(exp.useRegisterA), 32'(control.useRegisterA));
        checkValue("control.immKind", 32'(exp.immKind), 32'(control.immKind));
        checkValue("control.ramAddrFromAlu", 32'(exp.ramAddrFromAlu),
                   32'(control.ramAddrFromAlu));
        checkValue("control.writeBackFromRam", 32'(exp.writeBackFromRam),
                   32'(control.writeBackFromRam));
        checkValue("control.regWriteAddress", 32'(exp.regWriteAddress),
                   32'(control.regWriteAddress));
    endtask

    initial begin
        cpuControlPkg::stateT        expState;
        cpuControlPkg::controlLinesT expected;
        logic [31:0]                 bits;
        logic [15:0]                 instrNext;
        int                          issued;
        int                          cyclesSinceLoad;
        int                          pcCount;
        logic                        lastPcEnable;
        logic                        done;
        reset           = 1'b0;
        instruction     = '0;
        flags           = '0;
        lfsrState       = 32'hb7c3b0bc;
        errorCount      = 0;
        checkCount      = 0;
        issued          = 0;
        cyclesSinceLoad = 0;
        pcCount         = 0;
        lastPcEnable    = 1'b0;
        done            = 1'b0;
        expState        = cpuControlPkg::fetch;

        repeat (RESET_CYCLES) begin
            @(negedge clock);
            compareControl('0);
        end
        @(posedge clock);
        #1;
        reset = 1'b1;

        while (!done) begin
            if (expState == cpuControlPkg::decode) begin   // Cycle after irLoad
                randomBits(16, bits);
                instrNext = bits[15:0];
                if (instrNext[`OPCODE_MSB:`OPCODE_LSB] == cpuControlPkg::opMemJump) begin
                    randomBits(3, bits);
                    if (!bits[2]) instrNext[`EXT_MSB:`EXT_LSB] = {bits[1:0], 2'b00};
                end
                randomBits(5, bits);
                instruction = instrNext;
                flags       = cpuControlPkg::flagsT'(bits[4:0]);
                issued++;
            end
            @(negedge clock);
            expected = modelLines(expState, instruction, flags);
            compareControl(expected);
            if (control.irLoad) begin
                if (issued > 0) begin
                    checkValue("cycles per instruction", 32'(modelLength(modelClass(instruction))),
                               32'(cyclesSinceLoad));
                    checkValue("pcEnable count", 32'd1, 32'(pcCount));
                    checkValue("pcEnable in last cycle", 32'd1, 32'(lastPcEnable));
                end
                cyclesSinceLoad = 0;
                pcCount         = 0;
            end
            cyclesSinceLoad++;
            if (control.pcEnable) pcCount++;
            lastPcEnable = control.pcEnable;
            if (expState == cpuControlPkg::fetch && issued == NUM_INSTRUCTIONS) done = 1'b1;
            expState = modelNextState(expState, modelClass(instruction));
            @(posedge clock);
            #1;
        end

        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: cpuControl_macros.svh
`ifndef CPU_CONTROL_MACROS_SVH
`define CPU_CONTROL_MACROS_SVH

// Instruction word and register file sizes
`define INSTR_WIDTH 16
`define REG_ADDR_WIDTH 4

// Processor status word, one bit per flag
`define FLAG_WIDTH 5

// Major opcode
`define OPCODE_MSB 15
`define OPCODE_LSB 12

// Destination register, or condition code for jumps and branches
`define DEST_MSB 11
`define DEST_LSB 8

// Extended opcode
`define EXT_MSB 7
`define EXT_LSB 4

`endif

// File: instructionDecoder.sv
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module instructionDecoder (
    input  logic [`INSTR_WIDTH-1:0] instruction,
    output cpuControlPkg::decodeT   decoded
);

    cpuControlPkg::opcodeT              opcode;
    logic [`EXT_MSB-`EXT_LSB:0]         ext;
    logic                               registerShift;

    assign opcode = cpuControlPkg::opcodeT'(instruction[`OPCODE_MSB:`OPCODE_LSB]);
    assign ext    = instruction[`EXT_MSB:`EXT_LSB];

    assign registerShift = (ext == cpuControlPkg::extLsh) || (ext == cpuControlPkg::extAsh);

    always_comb begin
        decoded.instrClass   = cpuControlPkg::classIllegal;
        decoded.useImmediate = 1'b0;
        decoded.immKind      = cpuControlPkg::immRaw;
        case (opcode)
            cpuControlPkg::opRType: begin
                if (ext == cpuControlPkg::extCmp) begin
                    decoded.instrClass = cpuControlPkg::classCompare;
                end else begin
                    decoded.instrClass = cpuControlPkg::classAlu;
                end
            end
            cpuControlPkg::opAndi,
            cpuControlPkg::opOri,
            cpuControlPkg::opXori,
            cpuControlPkg::opMovi: begin
                decoded.instrClass   = cpuControlPkg::classAlu;
                decoded.useImmediate = 1'b1;
                decoded.immKind      = cpuControlPkg::immZeroExt;   // Logic ops take unsigned
            end
            cpuControlPkg::opAddi,
            cpuControlPkg::opSubi: begin
                decoded.instrClass   = cpuControlPkg::classAlu;
                decoded.useImmediate = 1'b1;
                decoded.immKind      = cpuControlPkg::immSignExt;
            end
            cpuControlPkg::opCmpi: begin
                decoded.instrClass   = cpuControlPkg::classCompare;
                decoded.useImmediate = 1'b1;
                decoded.immKind      = cpuControlPkg::immSignExt;
            end
            cpuControlPkg::opLui: begin
                decoded.instrClass   = cpuControlPkg::classAlu;
                decoded.useImmediate = 1'b1;
            end
            cpuControlPkg::opShift: begin
                decoded.instrClass   = cpuControlPkg::classAlu;
                decoded.useImmediate = !registerShift;   // LSHI and ASHUI use the amount field
            end
            cpuControlPkg::opMemJump: begin
                case (ext)
                    cpuControlPkg::extLoad: begin
                        decoded.instrClass = cpuControlPkg::classLoad;
                    end
                    cpuControlPkg::extStore: begin
                        decoded.instrClass   = cpuControlPkg::classStore;
                        decoded.useImmediate = 1'b1;
                        decoded.immKind      = cpuControlPkg::immZero;
                    end
                    cpuControlPkg::extJcond: begin
                        decoded.instrClass   = cpuControlPkg::classJcond;
                        decoded.useImmediate = 1'b1;
                        decoded.immKind      = cpuControlPkg::immZero;   // Target is Rsrc + 0
                    end
                    cpuControlPkg::extJal: begin
                        decoded.instrClass   = cpuControlPkg::classJal;
                        decoded.useImmediate = 1'b1;
                        decoded.immKind      = cpuControlPkg::immZero;
                    end
                    default: begin
                        decoded.instrClass = cpuControlPkg::classIllegal;
                    end
                endcase
            end
            cpuControlPkg::opBcond: begin
                decoded.instrClass   = cpuControlPkg::classBcond;
                decoded.useImmediate = 1'b1;   // PC plus displacement
            end
            cpuControlPkg::opAddui,
            cpuControlPkg::opAddci,
            cpuControlPkg::opSubci,
            cpuControlPkg::opMuli: begin
                decoded.instrClass = cpuControlPkg::classIllegal;
            end
        endcase
        // Bcond takes the PC as ALU operand A
        decoded.useRegisterA = (decoded.instrClass != cpuControlPkg::classBcond);
    end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the cpuControl testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cpuControlTb \
    -f cpuControl.f \
    -o simCpuControl

./obj_dir/simCpuControl | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
